/* rtl/mipsPkg.sv */
// shared widths, encodings and decoded control fields of the integer core
// opcode and funct lists hold only the supported instructions
package mipsPkg;

	parameter int DataWidth    = 32;
	parameter int RegAddrWidth = 5;

	parameter logic [RegAddrWidth-1:0] LinkReg    = 5'd31;
	parameter logic [DataWidth-1:0]    LinkOffset = 32'd4;

	// primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		OpSpecial = 6'b000000,
		OpJ       = 6'b000010,
		OpJal     = 6'b000011,
		OpBeq     = 6'b000100,
		OpBne     = 6'b000101,
		OpBlez    = 6'b000110,
		OpBgtz    = 6'b000111,
		OpAddi    = 6'b001000,
		OpAddiu   = 6'b001001,
		OpSlti    = 6'b001010,
		OpSltiu   = 6'b001011,
		OpAndi    = 6'b001100,
		OpOri     = 6'b001101,
		OpXori    = 6'b001110,
		OpLui     = 6'b001111
	} opcodeT;

	// special functs, instr[5:0]
	typedef enum logic [5:0] {
		FnSll  = 6'b000000,
		FnSrl  = 6'b000010,
		FnSra  = 6'b000011,
		FnJr   = 6'b001000,
		FnJalr = 6'b001001,
		FnAdd  = 6'b100000,
		FnAddu = 6'b100001,
		FnSub  = 6'b100010,
		FnSubu = 6'b100011,
		FnAnd  = 6'b100100,
		FnOr   = 6'b100101,
		FnXor  = 6'b100110,
		FnNor  = 6'b100111,
		FnSlt  = 6'b101010,
		FnSltu = 6'b101011
	} functT;

	typedef enum logic [3:0] {
		AluAdd, AluSub, AluAnd, AluOr, AluXor, AluNor,
		AluSlt, AluSltu, AluSll, AluSrl, AluSra, AluLui
	} aluOpT;

	typedef struct packed {
		logic  regWrite;
		logic  aluSrc;
		logic  zeroExt;
		logic  link;
		aluOpT aluOp;
	} ctrlT;

	// no write-back, no side effects
	parameter ctrlT NopCtrl = '{regWrite: 1'b0, aluSrc: 1'b0, zeroExt: 1'b0,
		link: 1'b0, aluOp: AluAdd};

endpackage

/* rtl/decodeExecIf.sv */
// one decoded instruction between decode and execute
// no handshake, valid marks a real instruction
`timescale 1ns/10ps

interface decodeExecIf;

	logic                                valid;
	mipsPkg::ctrlT                       ctrl;
	logic [mipsPkg::DataWidth-1:0]       opA;
	logic [mipsPkg::DataWidth-1:0]       opB;
	logic [4:0]                          shamt;
	logic [mipsPkg::RegAddrWidth-1:0]    destReg;

	modport decodeSide (
		output valid,
		output ctrl,
		output opA,
		output opB,
		output shamt,
		output destReg
	);

	modport executeSide (
		input valid,
		input ctrl,
		input opA,
		input opB,
		input shamt,
		input destReg
	);

endinterface

/* rtl/decodeStage.sv */
// decode with branch compare, next address and the decode/execute register
// no forwarding; destinations at or above RegCount write nothing
// bubble wins over freeze; unknown encodings become no-ops
`timescale 1ns/10ps

module decodeStage #(
	parameter int RegCount = 32
) (
	input  logic                                CLK,
	input  logic                                RESET,
	input  logic [mipsPkg::DataWidth-1:0]       instr,
	input  logic [mipsPkg::DataWidth-1:0]       pca,
	input  logic                                freeze,
	input  logic                                bubble,
	output logic [mipsPkg::RegAddrWidth-1:0]    rsAddr,
	output logic [mipsPkg::RegAddrWidth-1:0]    rtAddr,
	input  logic [mipsPkg::DataWidth-1:0]       rsData,
	input  logic [mipsPkg::DataWidth-1:0]       rtData,
	output logic [mipsPkg::DataWidth-1:0]       nextPc,
	output logic                                takenBranch,
	decodeExecIf.decodeSide                     toExec
);

	mipsPkg::opcodeT                     opcode;
	mipsPkg::functT                      funct;
	mipsPkg::ctrlT                       ctrlDec;
	mipsPkg::ctrlT                       ctrl;
	logic                                destRd;
	logic                                destLink;
	logic                                jump;
	logic                                jumpReg;
	logic [mipsPkg::RegAddrWidth-1:0]    destReg;
	logic [mipsPkg::DataWidth-1:0]       immSext;
	logic [mipsPkg::DataWidth-1:0]       immExt;
	logic [mipsPkg::DataWidth-1:0]       jumpTarget;
	logic [mipsPkg::DataWidth-1:0]       branchTarget;

	function automatic mipsPkg::ctrlT aluCtrl(
		input logic           useImm,
		input logic           zext,
		input mipsPkg::aluOpT op
	);
		mipsPkg::ctrlT c;
		c = mipsPkg::NopCtrl;
		c.regWrite = 1'b1;
		c.aluSrc = useImm;
		c.zeroExt = zext;
		c.aluOp = op;
		return c;
	endfunction

	// ------------------------------
	// controller
	// ------------------------------
	assign opcode = mipsPkg::opcodeT'(instr[31:26]);
	assign funct  = mipsPkg::functT'(instr[5:0]);
	assign rsAddr = instr[25:21];
	assign rtAddr = instr[20:16];

	always_comb begin
		ctrlDec  = mipsPkg::NopCtrl;
		destRd   = 1'b0;
		destLink = 1'b0;
		jump     = 1'b0;
		jumpReg  = 1'b0;
		case (opcode)
			mipsPkg::OpSpecial: begin
				destRd = 1'b1;
				case (funct)
					mipsPkg::FnSll: ctrlDec = aluCtrl(1'b0, 1'b0, mipsPkg::AluSll);
					mipsPkg::FnSrl: ctrlDec = aluCtrl(1'b0, 1'b0, mipsPkg::AluSrl);
					mipsPkg::FnSra: ctrlDec = aluCtrl(1'b0, 1'b0, mipsPkg::AluSra);
					mipsPkg::FnAdd, mipsPkg::FnAddu: ctrlDec = aluCtrl(1'b0, 1'b0, mipsPkg::AluAdd);
					mipsPkg::FnSub, mipsPkg::FnSubu: ctrlDec = aluCtrl(1'b0, 1'b0, mipsPkg::AluSub);
					mipsPkg::FnAnd: ctrlDec = aluCtrl(1'b0, 1'b0, mipsPkg::AluAnd);
					mipsPkg::FnOr:  ctrlDec = aluCtrl(1'b0, 1'b0, mipsPkg::AluOr);
					mipsPkg::FnXor: ctrlDec = aluCtrl(1'b0, 1'b0, mipsPkg::AluXor);
					mipsPkg::FnNor: ctrlDec = aluCtrl(1'b0, 1'b0, mipsPkg::AluNor);
					mipsPkg::FnSlt: ctrlDec = aluCtrl(1'b0, 1'b0, mipsPkg::AluSlt);
					mipsPkg::FnSltu: ctrlDec = aluCtrl(1'b0, 1'b0, mipsPkg::AluSltu);
					mipsPkg::FnJr: begin
						jump    = 1'b1;
						jumpReg = 1'b1;
					end
					mipsPkg::FnJalr: begin
						ctrlDec      = aluCtrl(1'b0, 1'b0, mipsPkg::AluAdd);
						ctrlDec.link = 1'b1;
						jump         = 1'b1;
						jumpReg      = 1'b1;
					end
					default: ctrlDec = mipsPkg::NopCtrl;
				endcase
			end
			mipsPkg::OpJ: jump = 1'b1;
			mipsPkg::OpJal: begin
				ctrlDec      = aluCtrl(1'b0, 1'b0, mipsPkg::AluAdd);
				ctrlDec.link = 1'b1;
				destLink     = 1'b1;
				jump         = 1'b1;
			end
			mipsPkg::OpAddi, mipsPkg::OpAddiu: ctrlDec = aluCtrl(1'b1, 1'b0, mipsPkg::AluAdd);
			mipsPkg::OpSlti:  ctrlDec = aluCtrl(1'b1, 1'b0, mipsPkg::AluSlt);
			mipsPkg::OpSltiu: ctrlDec = aluCtrl(1'b1, 1'b0, mipsPkg::AluSltu);
			mipsPkg::OpAndi:  ctrlDec = aluCtrl(1'b1, 1'b1, mipsPkg::AluAnd);
			mipsPkg::OpOri:   ctrlDec = aluCtrl(1'b1, 1'b1, mipsPkg::AluOr);
			mipsPkg::OpXori:  ctrlDec = aluCtrl(1'b1, 1'b1, mipsPkg::AluXor);
			mipsPkg::OpLui:   ctrlDec = aluCtrl(1'b1, 1'b1, mipsPkg::AluLui);
			// branches and unknown opcodes write nothing
			default: ctrlDec = mipsPkg::NopCtrl;
		endcase
	end

	assign destReg = destRd ? instr[15:11] : (destLink ? mipsPkg::LinkReg : instr[20:16]);

	always_comb begin
		ctrl          = ctrlDec;
		ctrl.regWrite = ctrlDec.regWrite && (destReg < RegCount);
	end

	assign immSext = {{16{instr[15]}}, instr[15:0]};
	assign immExt  = ctrlDec.zeroExt ? {16'b0, instr[15:0]} : immSext;

	// ------------------------------
	// branch compare, next address
	// ------------------------------
	always_comb begin
		case (opcode)
			mipsPkg::OpBeq:  takenBranch = (rsData == rtData);
			mipsPkg::OpBne:  takenBranch = (rsData != rtData);
			mipsPkg::OpBlez: takenBranch = ($signed(rsData) <= 0);
			mipsPkg::OpBgtz: takenBranch = ($signed(rsData) > 0);
			default:         takenBranch = 1'b0;
		endcase
	end

	assign jumpTarget   = jumpReg ? rsData : {pca[31:28], instr[25:0], 2'b00};
	assign branchTarget = pca + (immSext << 2);
	assign nextPc       = jump ? jumpTarget : (takenBranch ? branchTarget : pca);

	// ------------------------------
	// decode/execute register
	// ------------------------------
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			toExec.valid <= 1'b0;
			toExec.ctrl  <= mipsPkg::NopCtrl;
		end else if (bubble) begin
			toExec.valid <= 1'b0;
			toExec.ctrl  <= mipsPkg::NopCtrl;
		end else if (!freeze) begin
			toExec.valid <= 1'b1;
			toExec.ctrl  <= ctrl;
		end
	end

	// link passes pca and 4 to the adder
	always_ff @(posedge CLK) begin
		if (!bubble && !freeze) begin
			toExec.opA     <= ctrlDec.link ? pca : rsData;
			toExec.opB     <= ctrlDec.link ? mipsPkg::LinkOffset
				: (ctrlDec.aluSrc ? immExt : rtData);
			toExec.shamt   <= instr[10:6];
			toExec.destReg <= destReg;
		end
	end

	// an empty slot never carries a write
	assert property (@(posedge CLK) disable iff (!RESET)
		!toExec.valid |-> !toExec.ctrl.regWrite);

endmodule

/* rtl/aluExecute.sv */
// 32-bit ALU and execute/result register; add and addi never trap
// wbValid is held low for as long as freeze is high
`timescale 1ns/10ps

module aluExecute (
	input  logic                                CLK,
	input  logic                                RESET,
	input  logic                                freeze,
	decodeExecIf.executeSide                    fromDecode,
	output logic                                wbValid,
	output logic [mipsPkg::RegAddrWidth-1:0]    wbReg,
	output logic [mipsPkg::DataWidth-1:0]       wbData
);

	logic [mipsPkg::DataWidth-1:0] result;
	logic                          wbValidQ;

	always_comb begin
		result = '0;
		case (fromDecode.ctrl.aluOp)
			mipsPkg::AluAdd:  result = fromDecode.opA + fromDecode.opB;
			mipsPkg::AluSub:  result = fromDecode.opA - fromDecode.opB;
			mipsPkg::AluAnd:  result = fromDecode.opA & fromDecode.opB;
			mipsPkg::AluOr:   result = fromDecode.opA | fromDecode.opB;
			mipsPkg::AluXor:  result = fromDecode.opA ^ fromDecode.opB;
			mipsPkg::AluNor:  result = ~(fromDecode.opA | fromDecode.opB);
			mipsPkg::AluSlt:  result[0] = $signed(fromDecode.opA) < $signed(fromDecode.opB);
			mipsPkg::AluSltu: result[0] = fromDecode.opA < fromDecode.opB;
			// shifts act on rt by shamt
			mipsPkg::AluSll:  result = fromDecode.opB << fromDecode.shamt;
			mipsPkg::AluSrl:  result = fromDecode.opB >> fromDecode.shamt;
			mipsPkg::AluSra:  result = $signed(fromDecode.opB) >>> fromDecode.shamt;
			mipsPkg::AluLui:  result = fromDecode.opB << 16;
			default:          result = '0;
		endcase
	end

	// ------------------------------
	// execute/result register
	// ------------------------------
	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			wbValidQ <= 1'b0;
			wbReg    <= '0;
			wbData   <= '0;
		end else if (!freeze) begin
			wbValidQ <= fromDecode.valid && fromDecode.ctrl.regWrite;
			if (fromDecode.valid) begin
				wbReg  <= fromDecode.destReg;
				wbData <= result;
			end
		end
	end

	assign wbValid = wbValidQ && !freeze;

	// operands from decode and the register file must be fully known
	assert property (@(posedge CLK) disable iff (!RESET)
		wbValid |-> !$isunknown(wbData));

endmodule

/* rtl/regFile.sv */
// register file, two combinational read ports and one write port
// not reset; register 0 and indexes at or above RegCount read as zero
`timescale 1ns/10ps

module regFile #(
	parameter int RegCount = 32
) (
	input  logic                                CLK,
	input  logic [mipsPkg::RegAddrWidth-1:0]    rsAddr,
	input  logic [mipsPkg::RegAddrWidth-1:0]    rtAddr,
	output logic [mipsPkg::DataWidth-1:0]       rsData,
	output logic [mipsPkg::DataWidth-1:0]       rtData,
	input  logic                                wbValid,
	input  logic [mipsPkg::RegAddrWidth-1:0]    wbReg,
	input  logic [mipsPkg::DataWidth-1:0]       wbData
);

	localparam int IdxWidth = $clog2(RegCount);

	logic [mipsPkg::DataWidth-1:0] regs [RegCount];

	// register 0 is never written
	always_ff @(posedge CLK) begin
		if (wbValid && wbReg != '0 && wbReg < RegCount) begin
			regs[wbReg[IdxWidth-1:0]] <= wbData;
		end
	end

	assign rsData = (rsAddr == '0 || rsAddr >= RegCount) ? '0 : regs[rsAddr[IdxWidth-1:0]];
	assign rtData = (rtAddr == '0 || rtAddr >= RegCount) ? '0 : regs[rtAddr[IdxWidth-1:0]];

	// decode masks destinations outside the file
	assert property (@(posedge CLK) wbValid |-> wbReg < RegCount);

endmodule

/* rtl/coreTop.sv */
// integer core slice: decode, execute and register file
// no forwarding, a result is readable three accepted cycles after issue
`timescale 1ns/10ps

module coreTop #(
	parameter int RegCount = 32
) (
	input  logic                                CLK,
	input  logic                                RESET,
	input  logic [mipsPkg::DataWidth-1:0]       instr,
	input  logic [mipsPkg::DataWidth-1:0]       pca,
	input  logic                                freeze,
	input  logic                                bubble,
	output logic [mipsPkg::DataWidth-1:0]       nextPc,
	output logic                                takenBranch,
	output logic                                wbValid,
	output logic [mipsPkg::RegAddrWidth-1:0]    wbReg,
	output logic [mipsPkg::DataWidth-1:0]       wbData
);

	logic [mipsPkg::RegAddrWidth-1:0] rsAddr;
	logic [mipsPkg::RegAddrWidth-1:0] rtAddr;
	logic [mipsPkg::DataWidth-1:0]    rsData;
	logic [mipsPkg::DataWidth-1:0]    rtData;

	decodeExecIf u_decodeExecIf ();

	decodeStage #(
		.RegCount (RegCount)
	) u_decodeStage (
		.CLK         (CLK),
		.RESET       (RESET),
		.instr       (instr),
		.pca         (pca),
		.freeze      (freeze),
		.bubble      (bubble),
		.rsAddr      (rsAddr),
		.rtAddr      (rtAddr),
		.rsData      (rsData),
		.rtData      (rtData),
		.nextPc      (nextPc),
		.takenBranch (takenBranch),
		.toExec      (u_decodeExecIf.decodeSide)
	);

	// freeze also gates the write-back here
	aluExecute u_aluExecute (
		.CLK        (CLK),
		.RESET      (RESET),
		.freeze     (freeze),
		.fromDecode (u_decodeExecIf.executeSide),
		.wbValid    (wbValid),
		.wbReg      (wbReg),
		.wbData     (wbData)
	);

	regFile #(
		.RegCount (RegCount)
	) u_regFile (
		.CLK     (CLK),
		.rsAddr  (rsAddr),
		.rtAddr  (rtAddr),
		.rsData  (rsData),
		.rtData  (rtData),
		.wbValid (wbValid),
		.wbReg   (wbReg),
		.wbData  (wbData)
	);

endmodule

/* sim/tbCore.sv */
// testbench for coreTop: register model, queued write-backs, checks as assertions
// dependent instructions are presented three accepted cycles apart (no forwarding)
`timescale 1ns/10ps

module tbCore;

	localparam int CycleLimit = 2000;
	localparam logic [5:0] AluFuncts [13] = '{6'h00, 6'h02, 6'h03, 6'h20, 6'h21, 6'h22,
		6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};

	typedef struct packed {
		logic        valid;
		logic [4:0]  dest;
		logic [31:0] data;
	} wbT;

	logic        CLK;
	logic        RESET;
	logic [31:0] instr;
	logic [31:0] pca;
	logic        freeze;
	logic        bubble;
	logic [31:0] nextPc;
	logic        takenBranch;
	logic        wbValid;
	logic [4:0]  wbReg;
	logic [31:0] wbData;

	wbT          presWb;
	wbT          curWb;
	wbT          pending [$];
	logic        expValid;
	logic        expTaken;
	logic [31:0] expNextPc;
	logic        idle;
	logic [31:0] model [32];
	integer      seed;
	int          errors;
	int          testStart;
	int          testsPassed;
	int          testsFailed;
	int          cycles;
	string       curTest;

	coreTop #(
		.RegCount (32)
	) u_coreTop (
		.CLK         (CLK),
		.RESET       (RESET),
		.instr       (instr),
		.pca         (pca),
		.freeze      (freeze),
		.bubble      (bubble),
		.nextPc      (nextPc),
		.takenBranch (takenBranch),
		.wbValid     (wbValid),
		.wbReg       (wbReg),
		.wbData      (wbData)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// ------------------------------
	// expected write-back queue
	// ------------------------------
	// an entry accepted at one edge reaches the port after the next accepted edge
	always @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			pending.delete();
			curWb <= '0;
		end else if (!freeze) begin
			if (bubble)
				pending.push_back('0);
			else
				pending.push_back(presWb);
			if (pending.size() > 1)
				curWb <= pending.pop_front();
		end
	end

	assign expValid = curWb.valid && !freeze;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", CycleLimit);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ------------------------------
	// checks
	// ------------------------------
	assert property (@(posedge CLK) disable iff (!RESET) wbValid == expValid)
		else begin
			errors++;
			$display("[FAIL] %s: wbValid expected %b, actual %b", curTest,
				$sampled(expValid), $sampled(wbValid));
		end

	assert property (@(posedge CLK) disable iff (!RESET) expValid |-> wbReg == curWb.dest)
		else begin
			errors++;
			$display("[FAIL] %s: wbReg expected %0d, actual %0d", curTest,
				$sampled(curWb.dest), $sampled(wbReg));
		end

	assert property (@(posedge CLK) disable iff (!RESET) expValid |-> wbData == curWb.data)
		else begin
			errors++;
			$display("[FAIL] %s: wbData expected %h, actual %h", curTest,
				$sampled(curWb.data), $sampled(wbData));
		end

	assert property (@(posedge CLK) disable iff (!RESET)
		nextPc == expNextPc && takenBranch == expTaken)
		else begin
			errors++;
			$display("[FAIL] %s: taken/nextPc expected %b/%h, actual %b/%h", curTest,
				$sampled(expTaken), $sampled(expNextPc), $sampled(takenBranch),
				$sampled(nextPc));
		end

	assert property (@(posedge CLK) disable iff (!RESET) idle |-> !wbValid && wbData == '0)
		else begin
			errors++;
			$display("[FAIL] %s: idle wbValid/wbData expected 0/0, actual %b/%h", curTest,
				$sampled(wbValid), $sampled(wbData));
		end

	// ------------------------------
	// instruction set rules
	// ------------------------------
	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	function automatic wbT predictWb(input logic [31:0] ins, input logic [31:0] pc);
		wbT          w;
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] imm;
		rs = model[ins[25:21]];
		rt = model[ins[20:16]];
		imm = sext16(ins[15:0]);
		w.valid = 1'b1;
		w.dest = ins[20:16];
		w.data = '0;
		case (ins[31:26])
			6'h00: begin
				w.dest = ins[15:11];
				case (ins[5:0])
					6'h00: w.data = rt << ins[10:6];
					6'h02: w.data = rt >> ins[10:6];
					6'h03: w.data = $signed(rt) >>> ins[10:6];
					6'h09: w.data = pc + 32'd4;
					6'h20, 6'h21: w.data = rs + rt;
					6'h22, 6'h23: w.data = rs - rt;
					6'h24: w.data = rs & rt;
					6'h25: w.data = rs | rt;
					6'h26: w.data = rs ^ rt;
					6'h27: w.data = ~(rs | rt);
					6'h2a: w.data = {31'b0, $signed(rs) < $signed(rt)};
					6'h2b: w.data = {31'b0, rs < rt};
					// jr and unknown functs
					default: w = '0;
				endcase
			end
			6'h03: begin
				w.dest = 5'd31;
				w.data = pc + 32'd4;
			end
			6'h08, 6'h09: w.data = rs + imm;
			6'h0a: w.data = {31'b0, $signed(rs) < $signed(imm)};
			6'h0b: w.data = {31'b0, rs < imm};
			6'h0c: w.data = rs & {16'b0, ins[15:0]};
			6'h0d: w.data = rs | {16'b0, ins[15:0]};
			6'h0e: w.data = rs ^ {16'b0, ins[15:0]};
			6'h0f: w.data = {ins[15:0], 16'b0};
			default: w = '0;
		endcase
		return w;
	endfunction

	// {taken, next address}
	function automatic logic [32:0] predictPc(input logic [31:0] ins, input logic [31:0] pc);
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] npc;
		logic        taken;
		rs = model[ins[25:21]];
		rt = model[ins[20:16]];
		npc = pc;
		taken = 1'b0;
		case (ins[31:26])
			6'h00: begin
				if (ins[5:1] == 5'b00100)
					npc = rs;
			end
			6'h02, 6'h03: npc = {pc[31:28], ins[25:0], 2'b00};
			6'h04: taken = (rs == rt);
			6'h05: taken = (rs != rt);
			6'h06: taken = ($signed(rs) <= 0);
			6'h07: taken = ($signed(rs) > 0);
			default: taken = 1'b0;
		endcase
		if (taken)
			npc = pc + (sext16(ins[15:0]) << 2);
		return {taken, npc};
	endfunction

	function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// one of the loaded registers 1 to 8
	function automatic logic [4:0] randReg();
		logic [31:0] r;
		r = $random(seed);
		return {2'b0, r[2:0]} + 5'd1;
	endfunction

	function automatic logic [31:0] randPc();
		logic [31:0] r;
		r = $random(seed);
		return {r[31:2], 2'b00};
	endfunction

	// ------------------------------
	// stimulus
	// ------------------------------
	task automatic present(input logic [31:0] ins, input logic [31:0] pc, input logic bub);
		wbT          w;
		logic [32:0] p;
		w = predictWb(ins, pc);
		p = predictPc(ins, pc);
		if (!bub && w.valid && w.dest != 5'd0)
			model[w.dest] = w.data;
		instr <= ins;
		pca <= pc;
		bubble <= bub;
		presWb <= w;
		expTaken <= p[32];
		expNextPc <= p[31:0];
		@(posedge CLK);
	endtask

	task automatic spaced(input logic [31:0] ins);
		logic [31:0] pc;
		pc = randPc();
		present(ins, pc, 1'b0);
		present(32'h0, pc + 32'd4, 1'b0);
		present(32'h0, pc + 32'd8, 1'b0);
	endtask

	// counts after the last write-back of the test has been checked
	task automatic finishTest();
		int n;
		@(negedge CLK);
		n = errors - testStart;
		if (n == 0)
			testsPassed++;
		else
			testsFailed++;
		$display("test %s: %0d errors", curTest, n);
		testStart = errors;
		@(posedge CLK);
	endtask

	initial begin
		logic [31:0] val;
		logic [31:0] pc;
		logic [4:0]  ra;
		logic [4:0]  rb;
		seed = 32'he26e;
		errors = 0;
		testStart = 0;
		testsPassed = 0;
		testsFailed = 0;
		cycles = 0;
		RESET = 1'b0;
		instr = '0;
		pca = '0;
		freeze = 1'b0;
		bubble = 1'b1;
		presWb = '0;
		expTaken = 1'b0;
		expNextPc = '0;
		idle = 1'b1;
		for (int i = 0; i < 32; i++)
			model[i] = '0;
		curTest = "reset";
		repeat (5) @(posedge CLK);
		RESET <= 1'b1;
		repeat (4) @(posedge CLK);
		finishTest();

		idle = 1'b0;
		curTest = "load";
		for (int r = 1; r <= 8; r++) begin
			val = $random(seed);
			spaced(iType(6'h0f, 5'd0, 5'(r), val[31:16]));
			spaced(iType(6'h0d, 5'(r), 5'(r), val[15:0]));
		end
		finishTest();

		curTest = "alu";
		for (int i = 0; i < 13; i++) begin
			val = $random(seed);
			spaced(rType(AluFuncts[i], randReg(), randReg(), 5'(9 + i), val[4:0]));
		end
		for (int i = 0; i < 16; i++) begin
			val = $random(seed);
			spaced(iType({3'b001, 3'(i)}, randReg(), 5'(22 + i % 8), val[15:0]));
		end
		finishTest();

		curTest = "branch";
		for (int i = 0; i < 8; i++) begin
			val = $random(seed);
			ra = randReg();
			rb = (i < 4) ? ra : randReg();
			if (i[1])
				rb = 5'd0;
			spaced(iType({4'b0001, i[1:0]}, ra, rb, val[15:0]));
		end
		spaced(iType(6'h06, 5'd0, 5'd0, 16'hfff0));
		spaced(iType(6'h07, 5'd0, 5'd0, 16'h0010));
		val = $random(seed);
		spaced({6'h02, val[25:0]});
		spaced(rType(6'h08, randReg(), 5'd0, 5'd0, 5'd0));
		finishTest();

		curTest = "link";
		val = $random(seed);
		spaced({6'h03, val[25:0]});
		spaced(rType(6'h09, randReg(), 5'd0, 5'd10, 5'd0));
		spaced(rType(6'h08, 5'd31, 5'd0, 5'd0, 5'd0));
		// write to register 0, then read it back through or
		spaced(iType(6'h09, 5'd1, 5'd0, 16'h1234));
		spaced(rType(6'h25, 5'd0, 5'd0, 5'd11, 5'd0));
		finishTest();

		curTest = "freeze";
		pc = randPc();
		present(iType(6'h09, randReg(), 5'd12, 16'h0042), pc, 1'b0);
		freeze <= 1'b1;
		present(32'h0, pc + 32'd4, 1'b0);
		repeat (4) @(posedge CLK);
		freeze <= 1'b0;
		present(32'h0, pc + 32'd8, 1'b0);
		// bubbled instruction must never write back
		present(iType(6'h09, 5'd1, 5'd13, 16'h0077), pc + 32'd12, 1'b1);
		spaced(iType(6'h09, randReg(), 5'd14, 16'h8001));
		finishTest();

		curTest = "unknown";
		pc = randPc();
		present(iType(6'h09, randReg(), 5'd15, 16'h0101), pc, 1'b0);
		present(iType(6'h37, randReg(), 5'd16, 16'h5555), pc + 32'd4, 1'b0);
		present(rType(6'h01, randReg(), randReg(), 5'd17, 5'd3), pc + 32'd8, 1'b0);
		present(iType(6'h0e, randReg(), 5'd18, 16'hf00f), pc + 32'd12, 1'b0);
		present(32'h0, pc + 32'd16, 1'b0);
		present(32'h0, pc + 32'd20, 1'b0);
		finishTest();

		$display("tests passed %0d, failed %0d, check errors %0d", testsPassed, testsFailed,
			errors);
		if (testsFailed == 0 && errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* list.f */
rtl/mipsPkg.sv
rtl/decodeExecIf.sv
rtl/decodeStage.sv
rtl/aluExecute.sv
rtl/regFile.sv
rtl/coreTop.sv
sim/tbCore.sv

/* run.sh */
#!/usr/bin/env bash
# builds coreTop with its testbench under Verilator and runs it
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tbCore \
	-f list.f -Mdir obj_dir -o simCore
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simCore > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TEST FAIL" "$logFile"; then
	exit 1
fi
exit 0
